//--- include/nnWeights.svh
// hidden layer, one row of input weights per neuron
localparam nnFixedPkg::actWord [0:nnFixedPkg::numHidden-1][0:nnFixedPkg::numInputs-1]
	hiddenWeights = '{
	'{
		-24'sd7, 24'sd2, 24'sd5, 24'sd30, 24'sd13, -24'sd12, 24'sd24, -24'sd14,
		24'sd3, 24'sd5, -24'sd6, -24'sd14, 24'sd13, 24'sd0, 24'sd2
	},
	'{
		24'sd4, -24'sd3, 24'sd9, 24'sd1, -24'sd8, 24'sd6, 24'sd11, 24'sd2,
		-24'sd5, 24'sd7, 24'sd3, 24'sd10, -24'sd2, 24'sd8, 24'sd1
	},
	'{
		24'sd12, 24'sd7, -24'sd4, -24'sd9, 24'sd3, 24'sd15, -24'sd1, 24'sd6,
		24'sd9, -24'sd11, 24'sd4, 24'sd2, 24'sd5, -24'sd3, 24'sd10
	},
	'{
		-24'sd2, 24'sd9, 24'sd3, -24'sd6, 24'sd14, 24'sd1, 24'sd8, -24'sd10,
		24'sd6, 24'sd2, 24'sd11, -24'sd4, 24'sd7, 24'sd5, -24'sd8
	}
};

localparam nnFixedPkg::actWord [0:nnFixedPkg::numHidden-1] hiddenBias = '{
	24'sd5,
	-24'sd20,
	24'sd12,
	24'sd0
};

// output layer, hidden activations are 0..255 so these weights can reach saturation
localparam nnFixedPkg::actWord [0:nnFixedPkg::numOutputs-1][0:nnFixedPkg::numHidden-1]
	outWeights = '{
	'{
		24'sd20, -24'sd3, 24'sd9, 24'sd11
	},
	'{
		-24'sd16, 24'sd18, 24'sd5, 24'sd12
	}
};

localparam nnFixedPkg::actWord [0:nnFixedPkg::numOutputs-1] outBias = '{
	-24'sd40,
	24'sd24
};

//--- rtl/nnFixedPkg.sv
package nnFixedPkg;

	// activation, weight and sum word
	localparam int dataWidth = 24;

	typedef logic [dataWidth-1:0] actWord;

	// rectifier limits
	localparam actWord actMax = 24'd255; // saturated output
	localparam actWord satThreshold = 24'd8192; // sums at or above this saturate
	localparam int fracShift = 5; // low bit of the kept slice

	// network shape
	localparam int numInputs = 15;
	localparam int numHidden = 4;
	localparam int numOutputs = 2;

endpackage

//--- rtl/nnBusPkg.sv
package nnBusPkg;

	localparam int busWidth = 32;
	localparam int adrWidth = 5; // word address

	// register map, one word per address
	localparam logic [adrWidth-1:0] inputBase = 5'd0; // inputs 0..14
	localparam logic [adrWidth-1:0] controlAdr = 5'd16;
	localparam logic [adrWidth-1:0] statusAdr = 5'd17;
	localparam logic [adrWidth-1:0] outputBase = 5'd18; // outputs 18..19

	// field positions
	localparam int startBit = 0; // control, write 1 to start
	localparam int doneBit = 0; // status, sticky
	localparam int countLsb = 8; // status, completion count in 15:8

endpackage

//--- rtl/neuronNode.sv
module neuronNode #(
	parameter int fanIn = 15,
	parameter nnFixedPkg::actWord [0:fanIn-1] weights = '0,
	parameter nnFixedPkg::actWord bias = '0
) (
	input logic clk,
	input logic reset,
	input logic validIn,
	input nnFixedPkg::actWord inputs [fanIn],
	output logic validOut,
	output nnFixedPkg::actWord act
);
	import nnFixedPkg::*;

	localparam int sliceWidth = $clog2(actMax + 1); // 8 bit activation

	actWord inReg [fanIn]; // stage 1
	actWord sumNext;
	actWord sum; // stage 2
	logic [2:0] validPipe;

	// all arithmetic is modulo 2^24, so the low bits of an unsigned
	// product equal those of the signed one
	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < fanIn; i++)
		begin
			sumNext = sumNext + inReg[i] * weights[i];
		end
	end

	always_ff @(posedge clk)
	begin
		inReg <= inputs; // cycle 1
		sum <= sumNext; // cycle 2
		if (sum[dataWidth-1])
			act <= '0; // negative sum
		else if (sum >= satThreshold)
			act <= actMax;
		else
			act <= actWord'(sum[fracShift +: sliceWidth]); // zero extended
	end

	// valid travels alongside the three data stages
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[1:0], validIn};
	end

	assign validOut = validPipe[2];

endmodule

//--- rtl/denseLayer.sv
module denseLayer #(
	parameter int fanIn = 15,
	parameter int width = 4,
	parameter nnFixedPkg::actWord [0:width-1][0:fanIn-1] weights = '0,
	parameter nnFixedPkg::actWord [0:width-1] biases = '0
) (
	input logic clk,
	input logic reset,
	input logic validIn,
	input nnFixedPkg::actWord vectorIn [fanIn],
	output logic validOut,
	output nnFixedPkg::actWord vectorOut [width]
);

	logic [width-1:0] neuronValid;

	for (genvar i = 0; i < width; i++)
	begin : gNeuron
		neuronNode #(
			.fanIn(fanIn),
			.weights(weights[i]), // row i
			.bias(biases[i])
		) neuron_inst (
			.clk(clk),
			.reset(reset),
			.validIn(validIn),
			.inputs(vectorIn),
			.validOut(neuronValid[i]),
			.act(vectorOut[i])
		);
	end

	// all neurons share one timing
	assign validOut = neuronValid[0];

endmodule

//--- rtl/wbActivationPort.sv
module wbActivationPort #(
	parameter int numIn = 15,
	parameter int numOut = 2
) (
	input logic clk,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [nnBusPkg::adrWidth-1:0] wbAdr,
	input logic [nnBusPkg::busWidth-1:0] wbDatW,
	output logic [nnBusPkg::busWidth-1:0] wbDatR,
	output logic wbAck,
	output logic inValid,
	output nnFixedPkg::actWord inVector [numIn],
	input logic outValid,
	input nnFixedPkg::actWord outVector [numOut]
);
	import nnFixedPkg::*;
	import nnBusPkg::*;

	logic request;
	logic writeReq;
	logic startReq;
	logic startPending; // write acked, inValid goes out next cycle
	logic done;
	logic [7:0] count;
	actWord outReg [numOut];
	logic [busWidth-1:0] readData;

	assign request = wbCyc & wbStb & ~wbAck; // ack low again before next accept
	assign writeReq = request & wbWe;
	assign startReq = writeReq && (wbAdr == controlAdr) && wbDatW[startBit];

	// read mux, unmapped addresses give 0
	always_comb
	begin
		readData = '0;
		for (int i = 0; i < numIn; i++)
		begin
			if (wbAdr == adrWidth'(inputBase + i))
				readData = busWidth'(inVector[i]);
		end
		for (int i = 0; i < numOut; i++)
		begin
			if (wbAdr == adrWidth'(outputBase + i))
				readData = busWidth'(outReg[i]);
		end
		if (wbAdr == statusAdr)
		begin
			readData[doneBit] = done;
			readData[countLsb +: $bits(count)] = count;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wbAck <= 1'b0;
			wbDatR <= '0;
			startPending <= 1'b0;
			inValid <= 1'b0;
			done <= 1'b0;
			count <= '0;
			inVector <= '{default: '0};
			outReg <= '{default: '0};
		end
		else
		begin
			wbAck <= request; // single cycle ack
			startPending <= startReq;
			inValid <= startPending;
			if (request)
				wbDatR <= readData; // held while ack is high
			for (int i = 0; i < numIn; i++)
			begin
				if (writeReq && (wbAdr == adrWidth'(inputBase + i)))
					inVector[i] <= wbDatW[dataWidth-1:0];
			end
			if (startReq)
				done <= 1'b0;
			// a result landing on the same edge as a start still counts as done
			if (outValid)
			begin
				done <= 1'b1;
				count <= count + 8'd1; // wraps at 256
				outReg <= outVector;
			end
		end
	end

endmodule

//--- rtl/nnCore.sv
module nnCore (
	input logic clk,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [nnBusPkg::adrWidth-1:0] wbAdr,
	input logic [nnBusPkg::busWidth-1:0] wbDatW,
	output logic [nnBusPkg::busWidth-1:0] wbDatR,
	output logic wbAck
);
	import nnFixedPkg::*;

	`include "nnWeights.svh"

	logic inValid;
	actWord inVector [numInputs];
	logic hidValid;
	actWord hidVector [numHidden];
	logic outValid;
	actWord outVector [numOutputs];

	wbActivationPort #(
		.numIn(numInputs),
		.numOut(numOutputs)
	) busPort_inst (
		.clk(clk),
		.reset(reset),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.inValid(inValid),
		.inVector(inVector),
		.outValid(outValid),
		.outVector(outVector)
	);

	denseLayer #(
		.fanIn(numInputs),
		.width(numHidden),
		.weights(hiddenWeights),
		.biases(hiddenBias)
	) hiddenLayer_inst (
		.clk(clk),
		.reset(reset),
		.validIn(inValid),
		.vectorIn(inVector),
		.validOut(hidValid),
		.vectorOut(hidVector)
	);

	denseLayer #(
		.fanIn(numHidden),
		.width(numOutputs),
		.weights(outWeights),
		.biases(outBias)
	) outputLayer_inst (
		.clk(clk),
		.reset(reset),
		.validIn(hidValid),
		.vectorIn(hidVector),
		.validOut(outValid),
		.vectorOut(outVector)
	);

endmodule

//--- verification/nnCore_properties.sv
module nnCore_properties #(
	parameter int numOut = 2
) (
	input logic clk,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbAck,
	input logic outValid,
	input nnFixedPkg::actWord outVector [numOut]
);
	import nnFixedPkg::*;

	int ackFails = 0;
	int holdFails = 0;
	int rangeFails = 0;
	int resetFails = 0;
	int failCount; // summed for the testbench
	logic outOfRange;

	assign failCount = ackFails + holdFails + rangeFails + resetFails;

	always_comb
	begin
		outOfRange = 1'b0;
		for (int i = 0; i < numOut; i++)
		begin
			if (outVector[i] > actMax)
				outOfRange = 1'b1;
		end
	end

	// ack answers a request taken while ack was low
	ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
		wbAck |-> $past(wbCyc && wbStb && !wbAck))
	else
	begin
		$error("wbAck raised without a request on the cycle before");
		ackFails++;
	end

	ackSingleCycle: assert property (@(posedge clk) disable iff (reset)
		wbAck |=> !wbAck)
	else
	begin
		$error("wbAck stayed high for two cycles");
		holdFails++;
	end

	outputInRange: assert property (@(posedge clk) disable iff (reset)
		outValid |-> !outOfRange)
	else
	begin
		$error("layer output above the saturated activation");
		rangeFails++;
	end

	ackLowInReset: assert property (@(posedge clk)
		reset |=> !wbAck)
	else
	begin
		$error("wbAck high while reset is applied");
		resetFails++;
	end

endmodule

bind wbActivationPort nnCore_properties #(
	.numOut(numOut)
) props_inst (
	.clk(clk),
	.reset(reset),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbAck(wbAck),
	.outValid(outValid),
	.outVector(outVector)
);

//--- verification/nnCoreTb.sv
module nnCoreTb;
	import nnFixedPkg::*;
	import nnBusPkg::*;

	`include "nnWeights.svh"

	localparam int cycleLimit = 3000; // ~40 inferences of ~40 cycles plus margin
	localparam int randomVectors = 30;

	logic clk = 1'b0;
	logic reset;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [adrWidth-1:0] wbAdr;
	logic [busWidth-1:0] wbDatW;
	logic [busWidth-1:0] wbDatR;
	logic wbAck;

	int seed = 14;
	int cycleCount;
	int checkCount;
	int errorCount;
	int testErrors; // error count when the current test began
	int testNumber;
	int startCount;
	actWord stim [numInputs];
	actWord expOut [numOutputs];
	logic [busWidth-1:0] writeData [numInputs];
	logic [busWidth-1:0] readWord;

	nnCore nnCore_inst (
		.clk(clk),
		.reset(reset),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck)
	);

	initial
	begin
		forever #5 clk = ~clk;
	end

	task automatic busWrite(input logic [adrWidth-1:0] adr, input logic [busWidth-1:0] data);
		@(negedge clk);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbAdr = adr;
		wbDatW = data;
		do
		begin
			@(negedge clk);
		end
		while (wbAck !== 1'b1);
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic busRead(input logic [adrWidth-1:0] adr, output logic [busWidth-1:0] data);
		@(negedge clk);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b0;
		wbAdr = adr;
		do
		begin
			@(negedge clk);
		end
		while (wbAck !== 1'b1);
		data = wbDatR; // valid while ack is high
		wbCyc = 1'b0;
		wbStb = 1'b0;
	endtask

	task automatic checkValue(input string name, input logic [busWidth-1:0] got,
		input logic [busWidth-1:0] expected);
		checkCount++;
		assert (got === expected)
		else
		begin
			$display("[FAIL] %0t %s expected %h read %h", $time, name, expected, got);
			errorCount++;
		end
	endtask

	// saturating rectifier on a 24 bit two's complement sum
	function automatic actWord rectify(input actWord sum);
		if (sum[23])
			return '0;
		if (sum >= 24'd8192)
			return 24'd255;
		return actWord'(sum[12:5]);
	endfunction

	function automatic logic [busWidth-1:0] statusWord(input int starts, input logic done);
		logic [busWidth-1:0] word;
		word = '0;
		word[15:8] = starts[7:0]; // count wraps at 256
		word[0] = done;
		return word;
	endfunction

	task automatic modelForward();
		actWord hid [numHidden];
		actWord acc;
		for (int n = 0; n < numHidden; n++)
		begin
			acc = hiddenBias[n];
			for (int i = 0; i < numInputs; i++)
			begin
				acc = acc + stim[i] * hiddenWeights[n][i]; // modulo 2^24
			end
			hid[n] = rectify(acc);
		end
		for (int o = 0; o < numOutputs; o++)
		begin
			acc = outBias[o];
			for (int h = 0; h < numHidden; h++)
			begin
				acc = acc + hid[h] * outWeights[o][h];
			end
			expOut[o] = rectify(acc);
		end
	endtask

	task automatic runInference();
		logic [busWidth-1:0] status;
		logic [busWidth-1:0] result;
		for (int i = 0; i < numInputs; i++)
		begin
			busWrite(adrWidth'(inputBase + i), busWidth'(stim[i]));
		end
		busWrite(controlAdr, busWidth'(1) << startBit);
		startCount++;
		modelForward();
		do
		begin
			busRead(statusAdr, status);
		end
		while (status[doneBit] !== 1'b1);
		checkValue("status", status, statusWord(startCount, 1'b1));
		for (int o = 0; o < numOutputs; o++)
		begin
			busRead(adrWidth'(outputBase + o), result);
			checkValue($sformatf("output%0d", o), result, busWidth'(expOut[o]));
		end
	endtask

	task automatic finishTest(input string name);
		testNumber++;
		$display("test %0d %s: %0d errors", testNumber, name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	task automatic clearStim();
		for (int i = 0; i < numInputs; i++)
		begin
			stim[i] = '0;
		end
	endtask

	// watchdog
	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, the DUT never finished", cycleLimit);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		checkCount = 0;
		errorCount = 0;
		testErrors = 0;
		testNumber = 0;
		startCount = 0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		busRead(statusAdr, readWord);
		checkValue("status", readWord, '0);
		for (int o = 0; o < numOutputs; o++)
		begin
			busRead(adrWidth'(outputBase + o), readWord);
			checkValue($sformatf("output%0d", o), readWord, '0);
		end
		finishTest("reset values");

		for (int i = 0; i < numInputs; i++)
		begin
			writeData[i] = $random(seed);
			busWrite(adrWidth'(inputBase + i), writeData[i]);
		end
		for (int i = 0; i < numInputs; i++)
		begin
			busRead(adrWidth'(inputBase + i), readWord);
			checkValue($sformatf("input%0d", i), readWord, {8'h00, writeData[i][23:0]});
		end
		busRead(5'd15, readWord); // gap below control
		checkValue("unmapped 15", readWord, '0);
		busRead(5'd31, readWord);
		checkValue("unmapped 31", readWord, '0);
		finishTest("register readback");

		clearStim();
		stim[4] = 24'd400; // both outputs stay inside the linear slice
		stim[11] = 24'd500;
		runInference();
		finishTest("small vector");

		clearStim();
		stim[11] = 24'd500; // output 0 sum ends at -226
		runInference();
		busRead(outputBase, readWord);
		checkValue("output0", readWord, '0);
		finishTest("negative sum");

		clearStim();
		stim[12] = 24'd1000; // output 0 sum reaches 8862
		runInference();
		busRead(outputBase, readWord);
		checkValue("output0", readWord, 32'd255);
		finishTest("saturation");

		for (int v = 0; v < randomVectors; v++)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				stim[i] = actWord'($random(seed)) & 24'h000fff;
			end
			runInference();
		end
		finishTest("random vectors");

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", testNumber,
			checkCount, errorCount, nnCore_inst.busPort_inst.props_inst.failCount);
		if (errorCount == 0 && nnCore_inst.busPort_inst.props_inst.failCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
rtl/nnFixedPkg.sv
rtl/nnBusPkg.sv
rtl/neuronNode.sv
rtl/denseLayer.sv
rtl/wbActivationPort.sv
rtl/nnCore.sv
verification/nnCore_properties.sv
verification/nnCoreTb.sv

//--- Makefile
TOOL = verilator
TOP = nnCoreTb
FILELIST = filelist.f
BUILD_DIR = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS = --binary --timing --assert --Mdir $(BUILD_DIR)
RUN_FLAGS = +verilator+error+limit+100
PASS_MSG = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
